// File: common/reset_settings.svh
`ifndef RESET_SETTINGS_SVH
`define RESET_SETTINGS_SVH

// cycles from EOS release to start-up delay done
`define STARTUP_DLY 1000

// slow tick period in CLK cycles
`define SLOW_DIV 8

// limit for any waiting power-on state, in cycles
`define POR_TMO 120

// clock manager reset length
`define MMCM_RST_LEN 4

// trigger transceiver reset length
`define GTX_RST_LEN 6

// ADC init done limit, in slow ticks
`define ADC_TMO 50

// alignment length, in slow ticks
`define ALIGN_STEPS 32

`endif

// File: common/reset_seq_pkg.sv
`default_nettype none

package reset_seq_pkg;

    // power-on sequencer, one state per step of the bring-up
    typedef enum logic [3:0] {
        POR_IDLE        = 4'd0,  // start-up delay running
        POR_MMCM_RST    = 4'd1,
        POR_MMCM_WAIT   = 4'd2,
        POR_ADC_WAIT    = 4'd3,
        POR_ALIGN_START = 4'd4,
        POR_ALIGN_WAIT  = 4'd5,
        POR_BPI_WAIT    = 4'd6,
        POR_RUN         = 4'd7
    } por_state_t;

    // trigger transceiver starter
    typedef enum logic [1:0] {
        TRG_HOLD      = 2'd0,  // held by system reset
        TRG_GTX_RST   = 2'd1,
        TRG_LOCK_WAIT = 2'd2,
        TRG_READY     = 2'd3
    } trg_state_t;

endpackage

`default_nettype wire

// File: common/adc_pkg.sv
`default_nettype none

package adc_pkg;

    // ADC initializer states
    typedef enum logic [2:0] {
        ADC_OFF   = 3'd0,  // held by adc_init_rst
        ADC_RESET = 3'd1,
        ADC_INIT  = 3'd2,
        ADC_ALIGN = 3'd3,
        ADC_READY = 3'd4
    } adc_state_t;

    // deserializer alignment word
    typedef logic [4:0] align_cnt_t;

endpackage

`default_nettype wire

// File: verilog/startup_delay.sv
`timescale 1ns/10ps
`default_nettype none
`include "reset_settings.svh"

module startup_delay (
    input  wire  CLK,
    input  wire  EOS,
    output logic strt_dly_done_o,
    output logic slow_tick_o
);

    localparam int DLY_W = $clog2(`STARTUP_DLY + 1);
    localparam int DIV_W = $clog2(`SLOW_DIV);

    logic [DLY_W-1:0] dly_cnt;
    logic [DIV_W-1:0] div_cnt;

    assign strt_dly_done_o = (dly_cnt == DLY_W'(`STARTUP_DLY));

    always_ff @(posedge CLK or negedge EOS) begin
        if (!EOS) begin
            dly_cnt <= '0;
        end else if (!strt_dly_done_o) begin
            dly_cnt <= dly_cnt + 1'b1;  // saturates at the delay
        end
    end

    always_ff @(posedge CLK or negedge EOS) begin
        if (!EOS) begin
            div_cnt     <= '0;
            slow_tick_o <= 1'b0;
        end else begin
            slow_tick_o <= (div_cnt == DIV_W'(`SLOW_DIV - 1));
            if (div_cnt == DIV_W'(`SLOW_DIV - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: por/por_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "reset_settings.svh"

module por_sequencer (
    input  wire                       CLK,
    input  wire                       EOS,
    input  wire                       strt_dly_done_i,
    input  wire                       jtag_sys_rst_i,
    input  wire                       csp_sys_rst_i,
    input  wire                       daq_mmcm_lock_i,
    input  wire                       adc_rdy_i,
    input  wire                       al_done_i,
    input  wire                       bpi_seq_idle_i,
    output logic                      adc_init_rst_o,
    output logic                      al_start_o,
    output logic                      mmcm_rst_o,
    output logic                      sys_rst_o,
    output logic                      run_o,
    output logic                      dsr_rst_o,
    output reset_seq_pkg::por_state_t por_state_o
);

    import reset_seq_pkg::*;

    localparam int CNT_W = $clog2(`POR_TMO + `MMCM_RST_LEN);

    por_state_t       state_q;
    por_state_t       state_d;
    logic [CNT_W-1:0] state_cnt;
    logic [3:0]       sync_q1;
    logic [3:0]       sync_q2;
    logic             mmcm_lock_s;
    logic             adc_rdy_s;
    logic             al_done_s;
    logic             bpi_idle_s;
    logic             restart;
    logic             tmo;
    logic             run_next;

    assign restart     = jtag_sys_rst_i || csp_sys_rst_i;
    assign tmo         = (state_cnt == CNT_W'(`POR_TMO - 1));
    assign mmcm_lock_s = sync_q2[0];
    assign adc_rdy_s   = sync_q2[1];
    assign al_done_s   = sync_q2[2];
    assign bpi_idle_s  = sync_q2[3];
    assign run_next    = (state_q == POR_RUN) && (state_d == POR_RUN);
    assign por_state_o = state_q;
    assign dsr_rst_o   = !adc_rdy_i || sys_rst_o;

    always_ff @(posedge CLK or negedge EOS) begin
        if (!EOS) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= {bpi_seq_idle_i, al_done_i, adc_rdy_i, daq_mmcm_lock_i};
            sync_q2 <= sync_q1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            POR_IDLE: begin
                if (strt_dly_done_i) begin
                    state_d = POR_MMCM_RST;
                end
            end
            POR_MMCM_RST: begin
                if (state_cnt == CNT_W'(`MMCM_RST_LEN - 1)) begin
                    state_d = POR_MMCM_WAIT;
                end
            end
            POR_MMCM_WAIT: begin
                if (mmcm_lock_s) begin
                    state_d = POR_ADC_WAIT;
                end else if (tmo) begin
                    state_d = POR_MMCM_RST;
                end
            end
            POR_ADC_WAIT: begin
                if (adc_rdy_s) begin
                    state_d = POR_ALIGN_START;
                end else if (tmo) begin
                    state_d = POR_MMCM_RST;
                end
            end
            POR_ALIGN_START: state_d = POR_ALIGN_WAIT;  // single cycle
            POR_ALIGN_WAIT: begin
                if (al_done_s) begin
                    state_d = POR_BPI_WAIT;
                end else if (tmo) begin
                    state_d = POR_MMCM_RST;
                end
            end
            POR_BPI_WAIT: begin
                if (bpi_idle_s) begin
                    state_d = POR_RUN;
                end else if (tmo) begin
                    state_d = POR_MMCM_RST;
                end
            end
            POR_RUN: state_d = POR_RUN;
            default: state_d = POR_IDLE;
        endcase
        if (restart && (state_q != POR_IDLE)) begin
            state_d = POR_MMCM_RST;  // restart wins over everything
        end
    end

    always_ff @(posedge CLK or negedge EOS) begin
        if (!EOS) begin
            state_q        <= POR_IDLE;
            state_cnt      <= '0;
            adc_init_rst_o <= 1'b1;
            al_start_o     <= 1'b0;
            mmcm_rst_o     <= 1'b0;
            sys_rst_o      <= 1'b1;
            run_o          <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_d != state_q) || restart) begin
                state_cnt <= '0;
            end else begin
                state_cnt <= state_cnt + 1'b1;
            end
            adc_init_rst_o <= (state_d == POR_IDLE) || (state_d == POR_MMCM_RST) ||
                              (state_d == POR_MMCM_WAIT);
            al_start_o     <= (state_d == POR_ALIGN_START);
            mmcm_rst_o     <= (state_d == POR_MMCM_RST);
            sys_rst_o      <= !run_next;
            run_o          <= run_next;  // one cycle into POR_RUN
        end
    end

endmodule

`default_nettype wire

// File: trg/trg_clock_start.sv
`timescale 1ns/10ps
`default_nettype none
`include "reset_settings.svh"

module trg_clock_start (
    input  wire  CLK,
    input  wire  EOS,
    input  wire  sys_rst_i,
    input  wire  trg_mmcm_lock_i,
    input  wire  trg_sync_done_i,
    input  wire  cmp_phs_change_i,
    output logic trg_gtx_rst_o,
    output logic trg_rst_o
);

    import reset_seq_pkg::*;

    localparam int RST_W = $clog2(`GTX_RST_LEN + 1);

    trg_state_t       state_q;
    trg_state_t       state_d;
    logic [RST_W-1:0] rst_cnt;
    logic [1:0]       lock_q1;
    logic [1:0]       lock_q2;

    always_ff @(posedge CLK or negedge EOS) begin
        if (!EOS) begin
            lock_q1 <= '0;
            lock_q2 <= '0;
        end else begin
            lock_q1 <= {trg_sync_done_i, trg_mmcm_lock_i};
            lock_q2 <= lock_q1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            TRG_HOLD:      state_d = TRG_GTX_RST;  // only left once sys_rst is low
            TRG_GTX_RST: begin
                if (rst_cnt == RST_W'(`GTX_RST_LEN - 1)) begin
                    state_d = TRG_LOCK_WAIT;
                end
            end
            TRG_LOCK_WAIT: begin
                if (&lock_q2) begin
                    state_d = TRG_READY;
                end
            end
            TRG_READY:     state_d = TRG_READY;
            default:       state_d = TRG_HOLD;
        endcase
        if (cmp_phs_change_i && (state_q != TRG_HOLD)) begin
            state_d = TRG_GTX_RST;
        end
        if (sys_rst_i) begin
            state_d = TRG_HOLD;
        end
    end

    always_ff @(posedge CLK or negedge EOS) begin
        if (!EOS) begin
            state_q       <= TRG_HOLD;
            rst_cnt       <= '0;
            trg_gtx_rst_o <= 1'b1;
            trg_rst_o     <= 1'b1;
        end else begin
            state_q <= state_d;
            if ((state_d != state_q) || cmp_phs_change_i) begin
                rst_cnt <= '0;  // fresh reset length
            end else if (state_q == TRG_GTX_RST) begin
                rst_cnt <= rst_cnt + 1'b1;
            end
            trg_gtx_rst_o <= (state_d == TRG_HOLD) || (state_d == TRG_GTX_RST);
            trg_rst_o     <= (state_d != TRG_READY);
        end
    end

endmodule

`default_nettype wire

// File: adc/adc_init.sv
`timescale 1ns/10ps
`default_nettype none
`include "reset_settings.svh"

module adc_init (
    input  wire                 CLK,
    input  wire                 EOS,
    input  wire                 adc_init_rst_i,
    input  wire                 slow_tick_i,
    input  wire                 adc_init_done_i,
    output logic                adc_rst_o,
    output logic                adc_init_o,
    output logic                adc_rdy_o,
    output adc_pkg::align_cnt_t align_cnt_o
);

    import adc_pkg::*;

    localparam int TICK_W = $clog2(`ADC_TMO + `ALIGN_STEPS);

    adc_state_t        state_q;
    adc_state_t        state_d;
    logic [TICK_W-1:0] tick_cnt;
    logic              done_q1;
    logic              done_q2;

    always_ff @(posedge CLK or negedge EOS) begin
        if (!EOS) begin
            done_q1 <= 1'b0;
            done_q2 <= 1'b0;
        end else begin
            done_q1 <= adc_init_done_i;
            done_q2 <= done_q1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ADC_OFF:   state_d = ADC_RESET;
            ADC_RESET: begin
                if (slow_tick_i) begin
                    state_d = ADC_INIT;
                end
            end
            ADC_INIT: begin
                if (done_q2) begin
                    state_d = ADC_ALIGN;
                end else if (slow_tick_i && (tick_cnt == TICK_W'(`ADC_TMO - 1))) begin
                    state_d = ADC_RESET;  // init never finished
                end
            end
            ADC_ALIGN: begin
                if (slow_tick_i && (tick_cnt == TICK_W'(`ALIGN_STEPS - 1))) begin
                    state_d = ADC_READY;
                end
            end
            ADC_READY: state_d = ADC_READY;
            default:   state_d = ADC_OFF;
        endcase
        if (adc_init_rst_i) begin
            state_d = ADC_OFF;
        end
    end

    always_ff @(posedge CLK or negedge EOS) begin
        if (!EOS) begin
            state_q     <= ADC_OFF;
            tick_cnt    <= '0;
            align_cnt_o <= '0;
            adc_rst_o   <= 1'b1;
            adc_init_o  <= 1'b0;
            adc_rdy_o   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_d != state_q) begin
                tick_cnt <= '0;
            end else if (slow_tick_i) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            if ((state_q == ADC_ALIGN) && slow_tick_i) begin
                align_cnt_o <= align_cnt_o + 1'b1;  // one step per tick
            end else if (state_q != ADC_ALIGN && state_q != ADC_READY) begin
                align_cnt_o <= '0;
            end
            adc_rst_o  <= (state_d == ADC_OFF) || (state_d == ADC_RESET);
            adc_init_o <= (state_d == ADC_INIT);
            adc_rdy_o  <= (state_d == ADC_READY);
        end
    end

endmodule

`default_nettype wire

// File: verilog/reset_manager.sv
`timescale 1ns/10ps
`default_nettype none

module reset_manager (
    input  wire                            CLK,
    input  wire                            EOS,
    input  wire                            jtag_sys_rst_i,
    input  wire                            csp_sys_rst_i,
    input  wire                            daq_mmcm_lock_i,
    input  wire                            trg_mmcm_lock_i,
    input  wire                            cmp_phs_change_i,
    input  wire                            trg_sync_done_i,
    input  wire                            al_done_i,
    input  wire                            adc_init_done_i,
    input  wire                            bpi_seq_idle_i,
    output wire                            adc_init_o,
    output wire                            adc_rdy_o,
    output wire                            al_start_o,
    output wire                            trg_gtx_rst_o,
    output wire                            mmcm_rst_o,
    output wire                            adc_rst_o,
    output wire                            trg_rst_o,
    output wire                            dsr_rst_o,
    output wire                            sys_rst_o,
    output wire                            run_o,
    output wire reset_seq_pkg::por_state_t por_state_o,
    output wire adc_pkg::align_cnt_t       align_cnt_o
);

    wire strt_dly_done;
    wire slow_tick;
    wire adc_init_rst;

    startup_delay i_startup_delay (
        .CLK             (CLK),
        .EOS             (EOS),
        .strt_dly_done_o (strt_dly_done),
        .slow_tick_o     (slow_tick)
    );

    por_sequencer i_por_sequencer (
        .CLK             (CLK),
        .EOS             (EOS),
        .strt_dly_done_i (strt_dly_done),
        .jtag_sys_rst_i  (jtag_sys_rst_i),
        .csp_sys_rst_i   (csp_sys_rst_i),
        .daq_mmcm_lock_i (daq_mmcm_lock_i),
        .adc_rdy_i       (adc_rdy_o),  // fed back from the ADC initializer
        .al_done_i       (al_done_i),
        .bpi_seq_idle_i  (bpi_seq_idle_i),
        .adc_init_rst_o  (adc_init_rst),
        .al_start_o      (al_start_o),
        .mmcm_rst_o      (mmcm_rst_o),
        .sys_rst_o       (sys_rst_o),
        .run_o           (run_o),
        .dsr_rst_o       (dsr_rst_o),
        .por_state_o     (por_state_o)
    );

    trg_clock_start i_trg_clock_start (
        .CLK              (CLK),
        .EOS              (EOS),
        .sys_rst_i        (sys_rst_o),
        .trg_mmcm_lock_i  (trg_mmcm_lock_i),
        .trg_sync_done_i  (trg_sync_done_i),
        .cmp_phs_change_i (cmp_phs_change_i),
        .trg_gtx_rst_o    (trg_gtx_rst_o),
        .trg_rst_o        (trg_rst_o)
    );

    adc_init i_adc_init (
        .CLK             (CLK),
        .EOS             (EOS),
        .adc_init_rst_i  (adc_init_rst),
        .slow_tick_i     (slow_tick),
        .adc_init_done_i (adc_init_done_i),
        .adc_rst_o       (adc_rst_o),
        .adc_init_o      (adc_init_o),
        .adc_rdy_o       (adc_rdy_o),
        .align_cnt_o     (align_cnt_o)
    );

endmodule

`default_nettype wire

// File: testbench/reset_model.sv
`timescale 1ns/10ps
`default_nettype none
`include "reset_settings.svh"

module reset_model (
    input  wire                        CLK,
    input  wire                        EOS,
    input  wire                        restart_i,
    input  wire                        mmcm_lock_i,
    input  wire                        adc_rdy_i,
    input  wire                        al_done_i,
    input  wire                        bpi_idle_i,
    output reset_seq_pkg::por_state_t  state_o
);

    import reset_seq_pkg::*;

    int         dly;
    int         cnt;       // cycles spent in the current state
    logic [3:0] sync1;
    logic [3:0] sync2;     // status inputs after two-flop delay

    always_ff @(posedge CLK or negedge EOS) begin
        if (!EOS) begin
            dly     <= 0;
            cnt     <= 0;
            sync1   <= '0;
            sync2   <= '0;
            state_o <= POR_IDLE;
        end else begin
            sync1 <= {bpi_idle_i, al_done_i, adc_rdy_i, mmcm_lock_i};
            sync2 <= sync1;
            if (dly < `STARTUP_DLY) begin
                dly <= dly + 1;
            end
            cnt <= cnt + 1;
            if (restart_i && (state_o != POR_IDLE)) begin
                state_o <= POR_MMCM_RST;
                cnt     <= 0;
            end else begin
                case (state_o)
                    POR_IDLE: begin
                        if (dly == `STARTUP_DLY) begin
                            state_o <= POR_MMCM_RST;
                            cnt     <= 0;
                        end
                    end
                    POR_MMCM_RST: begin
                        if (cnt == `MMCM_RST_LEN - 1) begin
                            state_o <= POR_MMCM_WAIT;
                            cnt     <= 0;
                        end
                    end
                    POR_ALIGN_START: begin
                        state_o <= POR_ALIGN_WAIT;
                        cnt     <= 0;
                    end
                    POR_RUN: state_o <= POR_RUN;
                    default: begin
                        // the four waiting states, each on its own status bit
                        if (sync2[state_o == POR_MMCM_WAIT ? 0 :
                                  state_o == POR_ADC_WAIT  ? 1 :
                                  state_o == POR_ALIGN_WAIT ? 2 : 3]) begin
                            state_o <= (state_o == POR_MMCM_WAIT)  ? POR_ADC_WAIT :
                                       (state_o == POR_ADC_WAIT)   ? POR_ALIGN_START :
                                       (state_o == POR_ALIGN_WAIT) ? POR_BPI_WAIT : POR_RUN;
                            cnt     <= 0;
                        end else if (cnt == `POR_TMO - 1) begin
                            state_o <= POR_MMCM_RST;
                            cnt     <= 0;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_reset_manager.sv
`timescale 1ns/10ps
`default_nettype none
`include "reset_settings.svh"

module tb_reset_manager;

    import reset_seq_pkg::*;
    import adc_pkg::*;

    logic CLK;
    logic EOS;
    logic jtag_sys_rst_i;
    logic csp_sys_rst_i;
    logic daq_mmcm_lock_i;
    logic trg_mmcm_lock_i;
    logic cmp_phs_change_i;
    logic trg_sync_done_i;
    logic al_done_i;
    logic adc_init_done_i;
    logic bpi_seq_idle_i;
    wire  adc_init_o;
    wire  adc_rdy_o;
    wire  al_start_o;
    wire  trg_gtx_rst_o;
    wire  mmcm_rst_o;
    wire  adc_rst_o;
    wire  trg_rst_o;
    wire  dsr_rst_o;
    wire  sys_rst_o;
    wire  run_o;
    por_state_t por_state_o;
    align_cnt_t align_cnt_o;
    por_state_t exp_state;

    int         errors = 0;
    int         failures = 0;
    int         cycles;
    int         len;
    int         round;
    int         cyc;
    int         d_lock;
    int         d_done;
    int         d_al;
    int         d_bpi;
    int         d_trg;
    int         d_rst;
    int         d_cmp;
    int         rst_sel;
    por_state_t prev_state = POR_IDLE;
    logic       prev_sys_rst = 1'b1;
    logic       prev_restart = 1'b0;
    logic       prev_rdy = 1'b0;
    logic       prev_run = 1'b0;
    logic       prev_gtx = 1'b1;
    logic       prev_trg_rst = 1'b1;
    align_cnt_t prev_align = '0;
    int         steps = 0;
    int         gap = 0;
    int         gtx_len = 0;
    logic       exp_run;

    reset_manager i_dut (.*);

    reset_model i_model (
        .CLK         (CLK),
        .EOS         (EOS),
        .restart_i   (jtag_sys_rst_i || csp_sys_rst_i),
        .mmcm_lock_i (daq_mmcm_lock_i),
        .adc_rdy_i   (adc_rdy_o),
        .al_done_i   (al_done_i),
        .bpi_idle_i  (bpi_seq_idle_i),
        .state_o     (exp_state)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic check_por(input por_state_t got, input por_state_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_adc(input align_cnt_t got, input align_cnt_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // counts falling edges until the sequencer shows the wanted state
    task automatic wait_for_state(input por_state_t s, input int limit, output int n);
        n = 0;
        while (por_state_o != s && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (por_state_o != s) begin
            failures++;
            $display("Timeout at %0t waiting for state %s", $time, s.name());
        end
    endtask

    always @(negedge CLK) begin
        if (EOS) begin
            check_por(por_state_o, exp_state, "por_state_o");
            exp_run = (exp_state == POR_RUN) && (prev_state == POR_RUN);
            check_level(run_o, exp_run, "run_o");
            check_level(sys_rst_o, !exp_run, "sys_rst_o");
            check_level(mmcm_rst_o, exp_state == POR_MMCM_RST, "mmcm_rst_o");
            check_level(al_start_o, exp_state == POR_ALIGN_START, "al_start_o");
            check_level(dsr_rst_o, !adc_rdy_o || !exp_run, "dsr_rst_o");
            if (prev_restart && prev_state != POR_IDLE)
                check_por(por_state_o, POR_MMCM_RST, "state after restart");
            if (prev_state == POR_IDLE || prev_state == POR_MMCM_RST ||
                prev_state == POR_MMCM_WAIT) begin
                check_level(adc_rst_o, 1'b1, "adc_rst_o while held");
                check_level(adc_init_o, 1'b0, "adc_init_o while held");
                check_level(adc_rdy_o, 1'b0, "adc_rdy_o while held");
            end
            if (prev_sys_rst && sys_rst_o) begin
                check_level(trg_gtx_rst_o, 1'b1, "trg_gtx_rst_o in hold");
                check_level(trg_rst_o, 1'b1, "trg_rst_o in hold");
            end
            if (align_cnt_o != prev_align && !adc_rst_o) begin
                check_adc(align_cnt_o, align_cnt_t'(prev_align + 1'b1), "align_cnt_o step");
                if (steps > 0)
                    check_level(gap == `SLOW_DIV, 1'b1, "align step spacing");
                steps++;
                gap = 0;
            end
            gap++;
            if (adc_rst_o)
                steps = 0;
            if (adc_rdy_o && !prev_rdy)
                check_level(steps == `ALIGN_STEPS, 1'b1, "align steps before ready");
            if (run_o && !prev_run)
                check_level(daq_mmcm_lock_i && adc_rdy_o && al_done_i && bpi_seq_idle_i,
                            1'b1, "run conditions");
            if (trg_gtx_rst_o && !sys_rst_o && !prev_sys_rst)
                gtx_len++;
            if (!trg_gtx_rst_o && prev_gtx && !sys_rst_o)
                check_level(gtx_len == `GTX_RST_LEN, 1'b1, "trg_gtx_rst_o length");
            if (!trg_rst_o && prev_trg_rst)
                check_level(trg_mmcm_lock_i && trg_sync_done_i, 1'b1, "trg_rst_o release");
            if (cmp_phs_change_i || sys_rst_o)
                gtx_len = 0;
        end
        prev_state   = exp_state;
        prev_sys_rst = sys_rst_o;
        prev_restart = jtag_sys_rst_i || csp_sys_rst_i;
        prev_rdy     = adc_rdy_o;
        prev_run     = run_o;
        prev_gtx     = trg_gtx_rst_o;
        prev_trg_rst = trg_rst_o;
        prev_align   = align_cnt_o;
    end

    initial begin
        void'($urandom(86844));
        EOS              = 1'b0;
        jtag_sys_rst_i   = 1'b0;
        csp_sys_rst_i    = 1'b0;
        daq_mmcm_lock_i  = 1'b0;
        trg_mmcm_lock_i  = 1'b0;
        cmp_phs_change_i = 1'b0;
        trg_sync_done_i  = 1'b0;
        al_done_i        = 1'b0;
        adc_init_done_i  = 1'b0;
        bpi_seq_idle_i   = 1'b0;
        repeat (16) @(posedge CLK);
        #5 EOS = 1'b1;

        // start-up delay, then one clock-manager reset pulse
        wait_for_state(POR_MMCM_RST, `STARTUP_DLY + 20, cycles);
        check_level(cycles >= `STARTUP_DLY, 1'b1, "start-up delay length");
        len = 1;
        while (len < 50) begin
            @(negedge CLK);
            if (!mmcm_rst_o)
                break;
            len++;
        end
        check_level(len == `MMCM_RST_LEN, 1'b1, "mmcm_rst_o length");

        // lock withheld, the wait state times out
        wait_for_state(POR_MMCM_WAIT, 20, cycles);
        wait_for_state(POR_MMCM_RST, `POR_TMO + 10, cycles);
        check_level(cycles == `POR_TMO, 1'b1, "lock wait timeout length");

        // ADC init done withheld, ADC goes back into reset
        @(posedge CLK);
        #5 daq_mmcm_lock_i = 1'b1;
        cycles = 0;
        while (!adc_init_o && cycles < 500) begin
            @(negedge CLK);
            cycles++;
        end
        if (!adc_init_o) begin
            failures++;
            $display("Timeout at %0t: adc_init_o never went high", $time);
        end
        cycles = 0;
        while (adc_init_o && !adc_rst_o && cycles < `ADC_TMO * `SLOW_DIV + 200) begin
            @(negedge CLK);
            cycles++;
        end
        if (!adc_rst_o) begin
            failures++;
            $display("Timeout at %0t: adc_rst_o never returned high", $time);
        end

        for (round = 0; round < 4; round++) begin
            d_lock  = $urandom_range(1, 40);
            d_done  = $urandom_range(1, 60);
            d_al    = $urandom_range(1, 80);
            d_bpi   = $urandom_range(1, 80);
            d_trg   = $urandom_range(1, 60);
            d_rst   = $urandom_range(100, 500);
            d_cmp   = $urandom_range(50, 550);
            rst_sel = $urandom_range(0, 1);
            for (cyc = 0; cyc < 600; cyc++) begin
                @(posedge CLK);
                #5;
                jtag_sys_rst_i   = 1'b0;
                csp_sys_rst_i    = 1'b0;
                cmp_phs_change_i = 1'b0;
                if (cyc == 0) begin
                    daq_mmcm_lock_i = 1'b0;
                    adc_init_done_i = 1'b0;
                    al_done_i       = 1'b0;
                    bpi_seq_idle_i  = 1'b0;
                    trg_mmcm_lock_i = 1'b0;
                    trg_sync_done_i = 1'b0;
                end
                if (cyc == d_lock)
                    daq_mmcm_lock_i = 1'b1;
                if (cyc == d_done)
                    adc_init_done_i = 1'b1;
                if (cyc == d_al)
                    al_done_i = 1'b1;
                if (cyc == d_bpi)
                    bpi_seq_idle_i = 1'b1;
                if (cyc == d_trg) begin
                    trg_mmcm_lock_i = 1'b1;
                    trg_sync_done_i = 1'b1;
                end
                if (cyc == d_rst && rst_sel == 1)
                    jtag_sys_rst_i = 1'b1;
                if (cyc == d_rst && rst_sel == 0)
                    csp_sys_rst_i = 1'b1;
                if (cyc == d_cmp)
                    cmp_phs_change_i = 1'b1;
            end
        end

        @(negedge CLK);
        $display("errors: %0d mismatches, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: reset_manager.f
+incdir+common
common/reset_seq_pkg.sv
common/adc_pkg.sv
verilog/startup_delay.sv
por/por_sequencer.sv
trg/trg_clock_start.sv
adc/adc_init.sv
verilog/reset_manager.sv
testbench/reset_model.sv
testbench/tb_reset_manager.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wall -Wno-fatal \
    -f reset_manager.f --top-module tb_reset_manager -Mdir obj_dir

./obj_dir/Vtb_reset_manager > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
else
    exit 1
fi
